//--- include/id_params.svh
// decode stage widths; ID_REG_NUM must equal 2**ID_REG_AW and ID_XLEN is fixed at 64 for rv64i
`ifndef ID_PARAMS_SVH
`define ID_PARAMS_SVH

// register and pc width
`define ID_XLEN    64

// instruction word, no compressed encodings
`define ID_INST_WD 32

// register file address width
`define ID_REG_AW  5

// register count, x0 included
`define ID_REG_NUM 32

`endif

//--- hw/rv_isa_pkg.sv
// rv64i encoding types only; fence, system and compressed opcodes are left out on purpose
`default_nettype none

package rv_isa_pkg;

  // major opcode, inst[6:0]
  typedef enum logic [6:0] {
    opc_lui       = 7'b0110111,
    opc_auipc     = 7'b0010111,
    opc_jal       = 7'b1101111,
    opc_jalr      = 7'b1100111,
    opc_branch    = 7'b1100011,
    opc_load      = 7'b0000011,
    opc_store     = 7'b0100011,
    opc_op_imm    = 7'b0010011,
    opc_op        = 7'b0110011,
    opc_op_imm_32 = 7'b0011011,
    opc_op_32     = 7'b0111011
  } rv_opcode_e;

  // funct3 of conditional branches, 010 and 011 are reserved
  typedef enum logic [2:0] {
    br_beq  = 3'b000,
    br_bne  = 3'b001,
    br_blt  = 3'b100,
    br_bge  = 3'b101,
    br_bltu = 3'b110,
    br_bgeu = 3'b111
  } rv_br_funct_e;

endpackage

`default_nettype wire

//--- hw/id_ctrl_pkg.sv
// control field encodings handed to execute; values must match the execute stage decode
`default_nettype none

package id_ctrl_pkg;

  typedef enum logic [4:0] {
    alu_add       = 5'd0,
    alu_sub       = 5'd1,
    alu_sll       = 5'd2,
    alu_slt       = 5'd3,
    alu_sltu      = 5'd4,
    alu_xor       = 5'd5,
    alu_srl       = 5'd6,
    alu_sra       = 5'd7,
    alu_or        = 5'd8,
    alu_and       = 5'd9,
    alu_pass_src2 = 5'd10  // lui
  } alu_op_e;

  typedef enum logic {
    src1_rs1 = 1'b0,
    src1_pc  = 1'b1
  } alu_src1_e;

  typedef enum logic [1:0] {
    src2_rs2  = 2'd0,
    src2_imm  = 2'd1,
    src2_four = 2'd2  // link value
  } alu_src2_e;

  // same encoding as load/store funct3
  typedef enum logic [2:0] {
    mem_b  = 3'b000,
    mem_h  = 3'b001,
    mem_w  = 3'b010,
    mem_d  = 3'b011,
    mem_bu = 3'b100,
    mem_hu = 3'b101,
    mem_wu = 3'b110
  } mem_op_e;

  typedef enum logic [1:0] {
    kind_none = 2'd0,
    kind_cond = 2'd1,
    kind_jal  = 2'd2,
    kind_jalr = 2'd3
  } br_kind_e;

endpackage

`default_nettype wire

//--- hw/id_decoder.sv
// rv64i base decode only; unused register fields read as 0 and o_rd is 0 unless o_gpr_wen
`timescale 1ns/100ps
`default_nettype none
`include "id_params.svh"

module id_decoder (
  input  wire [`ID_INST_WD-1:0]     i_inst,
  output logic [`ID_REG_AW-1:0]     o_rs1,
  output logic [`ID_REG_AW-1:0]     o_rs2,
  output logic [`ID_REG_AW-1:0]     o_rd,
  output logic [`ID_XLEN-1:0]       o_imm,
  output id_ctrl_pkg::alu_op_e      o_alu_op,
  output id_ctrl_pkg::alu_src1_e    o_alu_src1,
  output id_ctrl_pkg::alu_src2_e    o_alu_src2,
  output logic                      o_word_op,
  output logic                      o_gpr_wen,
  output logic                      o_mem_ren,
  output logic                      o_mem_wen,
  output id_ctrl_pkg::mem_op_e      o_mem_op,
  output id_ctrl_pkg::br_kind_e     o_br_kind,
  output rv_isa_pkg::rv_br_funct_e  o_br_funct,
  output logic                      o_invalid
);
  import rv_isa_pkg::*;
  import id_ctrl_pkg::*;

  rv_opcode_e          opcode;
  logic [2:0]          funct3;
  logic                alt;        // inst[30]
  logic                funct7_ok;  // base or alternate funct7 for op/op-32
  logic                word_f3_ok;
  logic                use_rs1;
  logic                use_rs2;
  logic [`ID_XLEN-1:0] imm_i;
  logic [`ID_XLEN-1:0] imm_s;
  logic [`ID_XLEN-1:0] imm_b;
  logic [`ID_XLEN-1:0] imm_u;
  logic [`ID_XLEN-1:0] imm_j;

  function automatic alu_op_e funct_to_alu(input logic [2:0] f3, input logic sub_sra);
    case (f3)
      3'b000:  return sub_sra ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return sub_sra ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  assign opcode     = rv_opcode_e'(i_inst[6:0]);
  assign funct3     = i_inst[14:12];
  assign alt        = i_inst[30];
  assign word_f3_ok = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b101);
  assign funct7_ok  = (i_inst[31:25] == 7'b0000000) ||
                      (i_inst[31:25] == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

  assign imm_i = {{(`ID_XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(`ID_XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(`ID_XLEN-12){i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{(`ID_XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(`ID_XLEN-20){i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    o_imm      = imm_i;
    o_alu_op   = alu_add;
    o_alu_src1 = src1_rs1;
    o_alu_src2 = src2_rs2;
    o_word_op  = 1'b0;
    o_gpr_wen  = 1'b0;
    o_mem_ren  = 1'b0;
    o_mem_wen  = 1'b0;
    o_br_kind  = kind_none;
    use_rs1    = 1'b0;
    use_rs2    = 1'b0;
    o_invalid  = 1'b0;
    case (opcode)
      opc_lui: begin
        o_imm      = imm_u;
        o_alu_op   = alu_pass_src2;
        o_alu_src2 = src2_imm;
        o_gpr_wen  = 1'b1;
      end
      opc_auipc: begin
        o_imm      = imm_u;
        o_alu_src1 = src1_pc;
        o_alu_src2 = src2_imm;
        o_gpr_wen  = 1'b1;
      end
      opc_jal, opc_jalr: begin
        o_imm      = (opcode == opc_jal) ? imm_j : imm_i;
        o_alu_src1 = src1_pc;   // rd = pc + 4
        o_alu_src2 = src2_four;
        o_gpr_wen  = 1'b1;
        o_br_kind  = (opcode == opc_jal) ? kind_jal : kind_jalr;
        use_rs1    = (opcode == opc_jalr);
        o_invalid  = (opcode == opc_jalr) && (funct3 != 3'b000);
      end
      opc_branch: begin
        o_imm     = imm_b;
        o_br_kind = kind_cond;
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
        o_invalid = (funct3[2:1] == 2'b01);
      end
      opc_load: begin
        o_alu_src2 = src2_imm;
        o_gpr_wen  = 1'b1;
        o_mem_ren  = 1'b1;
        use_rs1    = 1'b1;
        o_invalid  = (funct3 == 3'b111);
      end
      opc_store: begin
        o_imm      = imm_s;
        o_alu_src2 = src2_imm;
        o_mem_wen  = 1'b1;
        use_rs1    = 1'b1;
        use_rs2    = 1'b1;
        o_invalid  = funct3[2];
      end
      opc_op_imm, opc_op_imm_32: begin
        o_alu_src2 = src2_imm;
        o_alu_op   = funct_to_alu(funct3, (funct3 == 3'b101) && alt);
        o_word_op  = (opcode == opc_op_imm_32);
        o_gpr_wen  = 1'b1;
        use_rs1    = 1'b1;
        o_invalid  = (opcode == opc_op_imm_32) && !word_f3_ok;
      end
      opc_op, opc_op_32: begin
        o_alu_op   = funct_to_alu(funct3, alt);
        o_word_op  = (opcode == opc_op_32);
        o_gpr_wen  = 1'b1;
        use_rs1    = 1'b1;
        use_rs2    = 1'b1;
        o_invalid  = !funct7_ok || ((opcode == opc_op_32) && !word_f3_ok);
      end
      default: o_invalid = 1'b1;
    endcase
    if (o_invalid) begin
      o_gpr_wen = 1'b0;
      o_mem_ren = 1'b0;
      o_mem_wen = 1'b0;
      o_br_kind = kind_none;
    end
  end

  assign o_rs1      = use_rs1 ? i_inst[19:15] : '0;
  assign o_rs2      = use_rs2 ? i_inst[24:20] : '0;
  assign o_rd       = o_gpr_wen ? i_inst[11:7] : '0;  // no false forwarding downstream
  assign o_mem_op   = mem_op_e'(funct3);
  assign o_br_funct = rv_br_funct_e'(funct3);

endmodule

`default_nettype wire

//--- hw/id_gpr_file.sv
// register file with asynchronous reads; a same-cycle write is not visible on the read ports
`timescale 1ns/100ps
`default_nettype none
`include "id_params.svh"

module id_gpr_file (
  input  wire                   i_clk,
  input  wire [`ID_REG_AW-1:0]  i_raddr1,
  input  wire [`ID_REG_AW-1:0]  i_raddr2,
  input  wire                   i_wen,
  input  wire [`ID_REG_AW-1:0]  i_waddr,
  input  wire [`ID_XLEN-1:0]    i_wdata,
  output logic [`ID_XLEN-1:0]   o_rdata1,
  output logic [`ID_XLEN-1:0]   o_rdata2
);

  logic [`ID_XLEN-1:0] regs [`ID_REG_NUM];

  // x0 never written
  always_ff @(posedge i_clk) begin
    if (i_wen && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

`default_nettype wire

//--- hw/id_hazard_unit.sv
// forwarding assumes each later stage presents rd = 0 when it does not write a register
`timescale 1ns/100ps
`default_nettype none
`include "id_params.svh"

module id_hazard_unit (
  input  wire [`ID_REG_AW-1:0]  i_rs1,
  input  wire [`ID_REG_AW-1:0]  i_rs2,
  input  wire [`ID_XLEN-1:0]    i_rf_rdata1,
  input  wire [`ID_XLEN-1:0]    i_rf_rdata2,
  input  wire                   i_es_load,
  input  wire [`ID_REG_AW-1:0]  i_es_rd,
  input  wire [`ID_XLEN-1:0]    i_es_result,
  input  wire [`ID_REG_AW-1:0]  i_ms_rd,
  input  wire [`ID_XLEN-1:0]    i_ms_result,
  input  wire [`ID_REG_AW-1:0]  i_ws_rd,
  input  wire [`ID_XLEN-1:0]    i_ws_result,
  output logic [`ID_XLEN-1:0]   o_rs1_data,
  output logic [`ID_XLEN-1:0]   o_rs2_data,
  output logic                  o_load_stall
);

  // youngest producer wins
  function automatic logic [`ID_XLEN-1:0] fwd(input logic [`ID_REG_AW-1:0] rs,
                                              input logic [`ID_XLEN-1:0]   rf_val);
    if (i_es_rd != '0 && rs == i_es_rd) begin
      return i_es_result;
    end else if (i_ms_rd != '0 && rs == i_ms_rd) begin
      return i_ms_result;
    end else if (i_ws_rd != '0 && rs == i_ws_rd) begin
      return i_ws_result;  // also covers the rf write in this cycle
    end
    return rf_val;
  endfunction

  always_comb begin
    o_rs1_data = fwd(i_rs1, i_rf_rdata1);
    o_rs2_data = fwd(i_rs2, i_rf_rdata2);
  end

  // load data only exists after mem, so the es value is not usable yet
  assign o_load_stall = i_es_load && (i_es_rd != '0) &&
                        ((i_es_rd == i_rs1) || (i_es_rd == i_rs2));

endmodule

`default_nettype wire

//--- hw/id_branch_unit.sv
// branches resolve in decode on forwarded operands; result is not meaningful during a load stall
`timescale 1ns/100ps
`default_nettype none
`include "id_params.svh"

module id_branch_unit (
  input  wire id_ctrl_pkg::br_kind_e     i_br_kind,
  input  wire rv_isa_pkg::rv_br_funct_e  i_br_funct,
  input  wire [`ID_XLEN-1:0]             i_rs1_data,
  input  wire [`ID_XLEN-1:0]             i_rs2_data,
  input  wire [`ID_XLEN-1:0]             i_pc,
  input  wire [`ID_XLEN-1:0]             i_imm,
  output logic                           o_taken,
  output logic [`ID_XLEN-1:0]            o_target
);
  import rv_isa_pkg::*;
  import id_ctrl_pkg::*;

  logic                eq;
  logic                lt_s;
  logic                lt_u;
  logic                cond_hit;
  logic [`ID_XLEN-1:0] jalr_sum;

  assign eq   = (i_rs1_data == i_rs2_data);
  assign lt_s = $signed(i_rs1_data) < $signed(i_rs2_data);
  assign lt_u = i_rs1_data < i_rs2_data;

  always_comb begin
    case (i_br_funct)
      br_beq:  cond_hit = eq;
      br_bne:  cond_hit = !eq;
      br_blt:  cond_hit = lt_s;
      br_bge:  cond_hit = !lt_s;
      br_bltu: cond_hit = lt_u;
      br_bgeu: cond_hit = !lt_u;
      default: cond_hit = 1'b0;  // reserved funct3, decoder flags it
    endcase
  end

  always_comb begin
    case (i_br_kind)
      kind_cond:           o_taken = cond_hit;
      kind_jal, kind_jalr: o_taken = 1'b1;
      default:             o_taken = 1'b0;
    endcase
  end

  assign jalr_sum = i_rs1_data + i_imm;
  assign o_target = (i_br_kind == kind_jalr) ? {jalr_sum[`ID_XLEN-1:1], 1'b0}
                                             : i_pc + i_imm;

endmodule

`default_nettype wire

//--- hw/id_stage.sv
// one-entry decode stage; outputs other than valid and taken are X until the first fetch
`timescale 1ns/100ps
`default_nettype none
`include "id_params.svh"

module id_stage (
  input  wire                        i_clk,
  input  wire                        i_rst,
  // fetch side
  input  wire                        i_fs_to_ds_valid,
  input  wire [`ID_INST_WD-1:0]      i_fs_inst,
  input  wire [`ID_XLEN-1:0]         i_fs_pc,
  output logic                       o_ds_allowin,
  // execute side
  input  wire                        i_es_allowin,
  input  wire                        i_es_load,
  output logic                       o_ds_to_es_valid,
  // bypass
  input  wire [`ID_REG_AW-1:0]       i_es_rd,
  input  wire [`ID_XLEN-1:0]         i_es_result,
  input  wire [`ID_REG_AW-1:0]       i_ms_rd,
  input  wire [`ID_XLEN-1:0]         i_ms_result,
  input  wire [`ID_REG_AW-1:0]       i_ws_rd,
  input  wire [`ID_XLEN-1:0]         i_ws_result,
  // write back
  input  wire                        i_rf_wen,
  input  wire [`ID_REG_AW-1:0]       i_rf_waddr,
  input  wire [`ID_XLEN-1:0]         i_rf_wdata,
  // to execute
  output logic [`ID_XLEN-1:0]        o_rs1_data,
  output logic [`ID_XLEN-1:0]        o_rs2_data,
  output logic [`ID_XLEN-1:0]        o_imm,
  output logic [`ID_XLEN-1:0]        o_pc,
  output logic [`ID_REG_AW-1:0]      o_rd,
  output id_ctrl_pkg::alu_op_e       o_alu_op,
  output id_ctrl_pkg::alu_src1_e     o_alu_src1,
  output id_ctrl_pkg::alu_src2_e     o_alu_src2,
  output logic                       o_word_op,
  output logic                       o_gpr_wen,
  output logic                       o_mem_ren,
  output logic                       o_mem_wen,
  output id_ctrl_pkg::mem_op_e       o_mem_op,
  output logic                       o_load,
  output logic                       o_invalid,
  // to fetch
  output logic                       o_br_taken,
  output logic [`ID_XLEN-1:0]        o_br_target,
  output logic                       o_br_stall
);
  import rv_isa_pkg::*;
  import id_ctrl_pkg::*;

  logic                  ds_valid;
  logic                  ds_ready_go;
  logic                  ds_load_stall;
  logic [`ID_INST_WD-1:0] ds_inst;
  logic [`ID_XLEN-1:0]   ds_pc;
  logic [`ID_REG_AW-1:0] rs1;
  logic [`ID_REG_AW-1:0] rs2;
  logic [`ID_XLEN-1:0]   rf_rdata1;
  logic [`ID_XLEN-1:0]   rf_rdata2;
  br_kind_e              br_kind;
  rv_br_funct_e          br_funct;
  logic                  br_hit;

  assign ds_ready_go      = !ds_load_stall;
  assign o_ds_allowin     = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid && o_ds_allowin) begin
      ds_inst <= i_fs_inst;
      ds_pc   <= i_fs_pc;
    end
  end

  assign o_pc       = ds_pc;
  assign o_load     = o_mem_ren;
  assign o_br_taken = ds_valid && br_hit;
  assign o_br_stall = o_br_taken && ds_load_stall;  // target built on stale rs data

  id_decoder u_decoder (
    .i_inst     (ds_inst),
    .o_rs1      (rs1),
    .o_rs2      (rs2),
    .o_rd       (o_rd),
    .o_imm      (o_imm),
    .o_alu_op   (o_alu_op),
    .o_alu_src1 (o_alu_src1),
    .o_alu_src2 (o_alu_src2),
    .o_word_op  (o_word_op),
    .o_gpr_wen  (o_gpr_wen),
    .o_mem_ren  (o_mem_ren),
    .o_mem_wen  (o_mem_wen),
    .o_mem_op   (o_mem_op),
    .o_br_kind  (br_kind),
    .o_br_funct (br_funct),
    .o_invalid  (o_invalid)
  );

  id_gpr_file u_gpr_file (
    .i_clk    (i_clk),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .i_wen    (i_rf_wen),
    .i_waddr  (i_rf_waddr),
    .i_wdata  (i_rf_wdata),
    .o_rdata1 (rf_rdata1),
    .o_rdata2 (rf_rdata2)
  );

  id_hazard_unit u_hazard_unit (
    .i_rs1        (rs1),
    .i_rs2        (rs2),
    .i_rf_rdata1  (rf_rdata1),
    .i_rf_rdata2  (rf_rdata2),
    .i_es_load    (i_es_load),
    .i_es_rd      (i_es_rd),
    .i_es_result  (i_es_result),
    .i_ms_rd      (i_ms_rd),
    .i_ms_result  (i_ms_result),
    .i_ws_rd      (i_ws_rd),
    .i_ws_result  (i_ws_result),
    .o_rs1_data   (o_rs1_data),
    .o_rs2_data   (o_rs2_data),
    .o_load_stall (ds_load_stall)
  );

  id_branch_unit u_branch_unit (
    .i_br_kind  (br_kind),
    .i_br_funct (br_funct),
    .i_rs1_data (o_rs1_data),
    .i_rs2_data (o_rs2_data),
    .i_pc       (ds_pc),
    .i_imm      (o_imm),
    .o_taken    (br_hit),
    .o_target   (o_br_target)
  );

endmodule

`default_nettype wire

//--- sim/id_stage_assertions.sv
// bound into id_stage; checks handshake and stall rules on rising edges outside reset
`timescale 1ns/100ps
`default_nettype none
`include "id_params.svh"

module id_stage_assertions (
  input wire                i_clk,
  input wire                i_rst,
  input wire                i_fs_valid,
  input wire                i_allowin,
  input wire                i_es_load,
  input wire                i_ds_valid,
  input wire                i_load_stall,
  input wire [`ID_XLEN-1:0] i_pc,
  input wire                i_to_es_valid,
  input wire                i_br_taken,
  input wire                i_br_stall
);

  // stage drained by an empty fetch slot
  a_valid_needs_stage: assert property (@(posedge i_clk) disable iff (i_rst)
    i_allowin && !i_fs_valid |=> !i_ds_valid && !i_to_es_valid)
    else $error("o_ds_to_es_valid high with an empty stage");

  a_stall_implies_taken: assert property (@(posedge i_clk) disable iff (i_rst)
    i_br_stall |-> i_br_taken && i_es_load && !i_allowin)
    else $error("o_br_stall high without a taken branch held by a load");

  // a held load consumer neither issues nor loses its slot
  a_no_issue_on_stall: assert property (@(posedge i_clk) disable iff (i_rst)
    i_load_stall && i_ds_valid |=> !$past(i_to_es_valid) && i_ds_valid && $stable(i_pc))
    else $error("o_ds_to_es_valid high or instruction lost during a load stall");

endmodule

`default_nettype wire

//--- sim/id_stage_tb.sv
// register file is filled before random reads; i_es_load is driven only in directed steps
`timescale 1ns/100ps
`default_nettype none
`include "id_params.svh"

module id_stage_tb;
  import rv_isa_pkg::*;
  import id_ctrl_pkg::*;

  logic        i_clk;
  logic        i_rst;
  logic        i_fs_to_ds_valid;
  logic [31:0] i_fs_inst;
  logic [63:0] i_fs_pc;
  logic        i_es_allowin;
  logic        i_es_load;
  logic [4:0]  i_es_rd, i_ms_rd, i_ws_rd;
  logic [63:0] i_es_result, i_ms_result, i_ws_result;
  logic        i_rf_wen;
  logic [4:0]  i_rf_waddr;
  logic [63:0] i_rf_wdata;
  logic        o_ds_allowin, o_ds_to_es_valid;
  logic [63:0] o_rs1_data, o_rs2_data, o_imm, o_pc, o_br_target;
  logic [4:0]  o_rd, o_alu_op;
  logic        o_alu_src1;
  logic [1:0]  o_alu_src2;
  logic [2:0]  o_mem_op;
  logic        o_word_op, o_gpr_wen, o_mem_ren, o_mem_wen, o_load, o_invalid;
  logic        o_br_taken, o_br_stall;

  logic [31:0] seed;
  int          mismatches;  // compare process
  int          failures;    // directed checks and timeouts
  logic [31:0] cur_inst;
  logic [63:0] cur_pc;
  logic [63:0] shadow [32];
  logic [63:0] exp_rs1, exp_rs2, exp_imm, exp_target;
  logic [4:0]  exp_rd, exp_alu;
  logic [1:0]  exp_src2, exp_kind;
  logic        exp_src1, exp_word, exp_wen, exp_ren, exp_mwen, exp_inv, exp_taken;

  id_stage i_id_stage (.*);

  bind id_stage id_stage_assertions u_assertions (
    .i_clk(i_clk), .i_rst(i_rst), .i_fs_valid(i_fs_to_ds_valid), .i_allowin(o_ds_allowin),
    .i_es_load(i_es_load), .i_ds_valid(ds_valid), .i_load_stall(ds_load_stall),
    .i_pc(ds_pc), .i_to_es_valid(o_ds_to_es_valid), .i_br_taken(o_br_taken),
    .i_br_stall(o_br_stall)
  );

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [63:0] rand64();
    return {lcg_next(), lcg_next()};
  endfunction

  function automatic logic [31:0] build_inst(input logic [31:0] rnd, input logic [6:0] opc,
      input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
    logic [31:0] w;
    w = rnd;
    w[6:0] = opc;
    w[11:7] = rd;
    w[14:12] = f3;
    w[19:15] = rs1;
    w[24:20] = rs2;
    return w;
  endfunction

  function automatic logic [4:0] alu_for(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0: return alt ? alu_sub : alu_add;
      3'd1: return alu_sll;
      3'd2: return alu_slt;
      3'd3: return alu_sltu;
      3'd4: return alu_xor;
      3'd5: return alt ? alu_sra : alu_srl;
      3'd6: return alu_or;
      default: return alu_and;
    endcase
  endfunction

  // youngest stage first, x0 never forwarded
  function automatic logic [63:0] fwd_val(input logic [4:0] r);
    if (r == 5'd0) return 64'd0;
    if (i_es_rd == r) return i_es_result;
    if (i_ms_rd == r) return i_ms_result;
    if (i_ws_rd == r) return i_ws_result;
    return shadow[r];
  endfunction

  function automatic void predict(input logic [31:0] inst, input logic [63:0] pc);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        u1, u2, w_ok, lt_s, lt_u;
    opc = inst[6:0];
    f3 = inst[14:12];
    f7 = inst[31:25];
    w_ok = (f3 == 3'd0) || (f3 == 3'd1) || (f3 == 3'd5);
    {u1, u2, exp_inv} = 3'b000;
    exp_imm = {{52{inst[31]}}, inst[31:20]};
    exp_alu = alu_add;
    exp_src1 = src1_rs1;
    exp_src2 = src2_rs2;
    {exp_word, exp_wen, exp_ren, exp_mwen} = 4'b0000;
    exp_kind = kind_none;
    if (opc == opc_lui || opc == opc_auipc) begin
      exp_imm = {{32{inst[31]}}, inst[31:12], 12'h000};
      exp_alu = (opc == opc_lui) ? alu_pass_src2 : alu_add;
      exp_src1 = (opc == opc_lui) ? src1_rs1 : src1_pc;
      exp_src2 = src2_imm;
      exp_wen = 1'b1;
    end else if (opc == opc_jal || opc == opc_jalr) begin
      if (opc == opc_jal) exp_imm = {{43{inst[31]}}, inst[31], inst[19:12], inst[20],
                                     inst[30:21], 1'b0};
      exp_src1 = src1_pc;
      exp_src2 = src2_four;
      exp_wen = 1'b1;
      exp_kind = (opc == opc_jal) ? kind_jal : kind_jalr;
      u1 = (opc == opc_jalr);
      exp_inv = (opc == opc_jalr) && (f3 != 3'd0);
    end else if (opc == opc_branch) begin
      exp_imm = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      exp_kind = kind_cond;
      {u1, u2} = 2'b11;
      exp_inv = (f3 == 3'd2) || (f3 == 3'd3);
    end else if (opc == opc_load) begin
      exp_src2 = src2_imm;
      {exp_wen, exp_ren, u1} = 3'b111;
      exp_inv = (f3 == 3'd7);
    end else if (opc == opc_store) begin
      exp_imm = {{52{inst[31]}}, inst[31:25], inst[11:7]};
      exp_src2 = src2_imm;
      {exp_mwen, u1, u2} = 3'b111;
      exp_inv = (f3 >= 3'd4);
    end else if (opc == opc_op_imm || opc == opc_op_imm_32) begin
      exp_src2 = src2_imm;
      exp_alu = alu_for(f3, (f3 == 3'd5) && inst[30]);
      exp_word = (opc == opc_op_imm_32);
      {exp_wen, u1} = 2'b11;
      exp_inv = exp_word && !w_ok;
    end else if (opc == opc_op || opc == opc_op_32) begin
      exp_alu = alu_for(f3, inst[30]);
      exp_word = (opc == opc_op_32);
      {exp_wen, u1, u2} = 3'b111;
      exp_inv = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)))
                || (exp_word && !w_ok);
    end else begin
      exp_inv = 1'b1;
    end
    if (exp_inv) begin
      {exp_wen, exp_ren, exp_mwen} = 3'b000;
      exp_kind = kind_none;
    end
    exp_rd = exp_wen ? inst[11:7] : 5'd0;
    exp_rs1 = fwd_val(u1 ? inst[19:15] : 5'd0);
    exp_rs2 = fwd_val(u2 ? inst[24:20] : 5'd0);
    lt_s = $signed(exp_rs1) < $signed(exp_rs2);
    lt_u = exp_rs1 < exp_rs2;
    case (f3)
      3'd0: exp_taken = (exp_rs1 == exp_rs2);
      3'd1: exp_taken = (exp_rs1 != exp_rs2);
      3'd4: exp_taken = lt_s;
      3'd5: exp_taken = !lt_s;
      3'd6: exp_taken = lt_u;
      3'd7: exp_taken = !lt_u;
      default: exp_taken = 1'b0;
    endcase
    if (exp_kind == kind_none) exp_taken = 1'b0;
    if (exp_kind == kind_jal || exp_kind == kind_jalr) exp_taken = 1'b1;
    exp_target = (exp_kind == kind_jalr) ? ((exp_rs1 + exp_imm) & ~64'h1) : pc + exp_imm;
  endfunction

  function automatic int check_field(input string name, input logic [63:0] got,
                                     input logic [63:0] exp);
    if (got !== exp) begin
      $display("error %s got 0x%h expected 0x%h", name, got, exp);
      return 1;
    end
    return 0;
  endfunction

  // compare at the falling edge, inputs settle 2 ns after the rising one
  always @(negedge i_clk) begin
    if (!i_rst) begin
      if (o_ds_to_es_valid) begin
        predict(cur_inst, cur_pc);
        mismatches += check_field("o_rs1_data", o_rs1_data, exp_rs1);
        mismatches += check_field("o_rs2_data", o_rs2_data, exp_rs2);
        mismatches += check_field("o_imm", o_imm, exp_imm);
        mismatches += check_field("o_pc", o_pc, cur_pc);
        mismatches += check_field("o_rd", 64'(o_rd), 64'(exp_rd));
        mismatches += check_field("o_alu_op", 64'(o_alu_op), 64'(exp_alu));
        mismatches += check_field("o_alu_src1", 64'(o_alu_src1), 64'(exp_src1));
        mismatches += check_field("o_alu_src2", 64'(o_alu_src2), 64'(exp_src2));
        mismatches += check_field("o_word_op", 64'(o_word_op), 64'(exp_word));
        mismatches += check_field("o_gpr_wen", 64'(o_gpr_wen), 64'(exp_wen));
        mismatches += check_field("o_mem_ren", 64'(o_mem_ren), 64'(exp_ren));
        mismatches += check_field("o_load", 64'(o_load), 64'(exp_ren));
        mismatches += check_field("o_mem_wen", 64'(o_mem_wen), 64'(exp_mwen));
        mismatches += check_field("o_mem_op", 64'(o_mem_op), 64'(cur_inst[14:12]));
        mismatches += check_field("o_invalid", 64'(o_invalid), 64'(exp_inv));
        mismatches += check_field("o_br_taken", 64'(o_br_taken), 64'(exp_taken));
        if (exp_taken) mismatches += check_field("o_br_target", o_br_target, exp_target);
      end
      if (i_fs_to_ds_valid && o_ds_allowin) begin
        cur_inst = i_fs_inst;
        cur_pc = i_fs_pc;
      end
      if (i_rf_wen && i_rf_waddr != 5'd0) shadow[i_rf_waddr] = i_rf_wdata;
    end
  end

  task automatic step();
    @(posedge i_clk);
    #2;
  endtask

  task automatic send(input logic [31:0] inst, input logic [63:0] pc);
    int n;
    i_fs_to_ds_valid = 1'b1;
    i_fs_inst = inst;
    i_fs_pc = pc;
    n = 0;
    @(negedge i_clk);
    while (!o_ds_allowin && n < 50) begin
      @(negedge i_clk);
      n++;
    end
    if (!o_ds_allowin) begin
      failures++;
      $display("timeout: decode stage never accepted the instruction");
    end
    step();
    i_fs_to_ds_valid = 1'b0;
  endtask

  task automatic write_reg(input logic [4:0] r, input logic [63:0] val);
    i_rf_wen = 1'b1;
    i_rf_waddr = r;
    i_rf_wdata = val;
    step();
    i_rf_wen = 1'b0;
  endtask

  task automatic set_fwd(input logic [4:0] e, input logic [4:0] m, input logic [4:0] w);
    i_es_rd = e;
    i_ms_rd = m;
    i_ws_rd = w;
    i_es_result = rand64();
    i_ms_result = rand64();
    i_ws_result = rand64();
  endtask

  task automatic check_now(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      failures++;
      $display("error %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  initial begin
    logic [31:0] pick;
    logic [31:0] inst;
    logic [2:0]  f3s [6];
    logic [63:0] snap_imm, snap_pc, snap_ctrl, snap_target;
    f3s = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    seed = 32'h05be_609b;
    mismatches = 0;
    failures = 0;
    i_rst = 1'b1;
    {i_fs_to_ds_valid, i_es_load, i_rf_wen} = 3'b000;
    i_es_allowin = 1'b1;
    i_fs_inst = 32'h0;
    i_fs_pc = 64'h0;
    i_rf_waddr = 5'd0;
    i_rf_wdata = 64'h0;
    {i_es_rd, i_ms_rd, i_ws_rd} = 15'h0;
    {i_es_result, i_ms_result, i_ws_result} = {3{64'h0}};
    repeat (4) @(posedge i_clk);
    #2;
    i_rst = 1'b0;
    // register file fill and readback, x0 included
    for (int r = 0; r < 32; r++) write_reg(5'(r), rand64() ^ {59'h0, 5'(r)});
    for (int r = 0; r < 32; r++) begin
      send(build_inst(32'h0, opc_op, 3'd0, 5'd1, 5'(r), 5'(31 - r)), 64'h1000);
    end
    // forwarding priority: es, ms, ws, then the register file
    for (int k = 0; k < 4; k++) begin
      send(build_inst(32'h0, opc_op, 3'd0, 5'd2, 5'd7, 5'd7), 64'h2000);
      set_fwd((k < 1) ? 5'd7 : 5'd0, (k < 2) ? 5'd7 : 5'd0, (k < 3) ? 5'd7 : 5'd0);
    end
    set_fwd(5'd0, 5'd0, 5'd0);
    send(build_inst(32'h0, opc_op, 3'd0, 5'd2, 5'd0, 5'd0), 64'h2004);
    // random decode with random bypass traffic
    for (int i = 0; i < 150; i++) begin
      pick = lcg_next();
      inst = lcg_next();
      case (pick[18:16] % 3'd6)
        3'd0: inst[6:0] = opc_op_imm;
        3'd1: inst = {pick[0] ? 7'h20 : 7'h00, inst[24:7], 7'(opc_op)};
        3'd2: inst[6:0] = opc_lui;
        3'd3: inst[6:0] = opc_auipc;
        3'd4: inst[6:0] = opc_load;
        default: inst[6:0] = opc_store;
      endcase
      set_fwd(pick[1] ? pick[8:4] : 5'd0, pick[2] ? pick[13:9] : 5'd0,
              pick[3] ? pick[24:20] : 5'd0);
      if (pick[27:26] == 2'b00) begin
        i_es_allowin = 1'b0;  // execute busy, previous instruction held a cycle
        step();
        i_es_allowin = 1'b1;
      end
      send(inst, rand64() & ~64'h3);
    end
    set_fwd(5'd0, 5'd0, 5'd0);
    // branches and jumps on known register values
    write_reg(5'd1, 64'hffff_ffff_ffff_fffb);
    write_reg(5'd2, 64'd3);
    write_reg(5'd3, 64'h0000_0000_8000_0123);
    for (int f = 0; f < 6; f++) begin
      send(build_inst(lcg_next(), opc_branch, f3s[f], 5'(lcg_next()), 5'd1, 5'd2), 64'h4000);
      send(build_inst(lcg_next(), opc_branch, f3s[f], 5'(lcg_next()), 5'd2, 5'd1), 64'h4004);
      send(build_inst(lcg_next(), opc_branch, f3s[f], 5'(lcg_next()), 5'd1, 5'd1), 64'h4008);
    end
    inst = lcg_next();
    send(build_inst(inst, opc_jal, inst[14:12], 5'd1, inst[19:15], inst[24:20]), 64'h5000);
    send(build_inst(lcg_next(), opc_jalr, 3'd0, 5'd1, 5'd3, 5'(lcg_next())), 64'h5004);
    // load-use on rs1 of a taken jalr, then on rs2 of an add
    set_fwd(5'd5, 5'd0, 5'd0);
    for (int t = 0; t < 2; t++) begin
      i_es_load = 1'b1;
      if (t == 0) send(build_inst(32'h0, opc_jalr, 3'd0, 5'd0, 5'd5, 5'd0), 64'h6000);
      else send(build_inst(32'h0, opc_op, 3'd0, 5'd1, 5'd2, 5'd5), 64'h6004);
      repeat (3) begin
        @(negedge i_clk);
        check_now("o_ds_to_es_valid", o_ds_to_es_valid, 1'b0);
        check_now("o_ds_allowin", o_ds_allowin, 1'b0);
        check_now("o_br_stall", o_br_stall, (t == 0));
      end
      step();
      i_es_load = 1'b0;
      @(negedge i_clk);
      check_now("o_ds_to_es_valid", o_ds_to_es_valid, 1'b1);
      check_now("o_br_stall", o_br_stall, 1'b0);
      step();
    end
    set_fwd(5'd0, 5'd0, 5'd0);
    // unknown opcode held by execute backpressure
    i_es_allowin = 1'b0;
    send(build_inst(lcg_next(), 7'b1110011, 3'd0, 5'd4, 5'd1, 5'd2), 64'h7000);
    @(negedge i_clk);
    check_now("o_invalid", o_invalid, 1'b1);
    check_now("o_gpr_wen", o_gpr_wen, 1'b0);
    check_now("o_mem_wen", o_mem_wen, 1'b0);
    snap_imm = o_imm;
    snap_pc = o_pc;
    snap_target = o_br_target;
    snap_ctrl = 64'({o_rd, o_alu_op, o_alu_src1, o_alu_src2, o_word_op, o_gpr_wen,
                     o_mem_ren, o_mem_wen, o_mem_op, o_load, o_invalid, o_br_taken,
                     o_br_stall, o_ds_to_es_valid});
    repeat (4) begin
      @(negedge i_clk);
      check_now("o_ds_allowin", o_ds_allowin, 1'b0);
      check_now("o_imm stable", o_imm == snap_imm, 1'b1);
      check_now("o_pc stable", o_pc == snap_pc, 1'b1);
      check_now("o_br_target stable", o_br_target == snap_target, 1'b1);
      check_now("control outputs stable", snap_ctrl == 64'({o_rd, o_alu_op, o_alu_src1,
        o_alu_src2, o_word_op, o_gpr_wen, o_mem_ren, o_mem_wen, o_mem_op, o_load,
        o_invalid, o_br_taken, o_br_stall, o_ds_to_es_valid}), 1'b1);
    end
    step();
    i_es_allowin = 1'b1;
    step();
    @(negedge i_clk);
    check_now("o_ds_to_es_valid", o_ds_to_es_valid, 1'b0);
    repeat (2) step();
    $display("errors: %0d (compare %0d, directed %0d)", mismatches + failures, mismatches,
             failures);
    if (mismatches + failures == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // hard stop if the sequence stalls
  initial begin
    #1_000_000;
    $display("timeout: stimulus did not complete");
    $display("errors: %0d", mismatches + failures + 1);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- id_stage.f
+incdir+include
hw/rv_isa_pkg.sv
hw/id_ctrl_pkg.sv
hw/id_decoder.sv
hw/id_gpr_file.sv
hw/id_hazard_unit.sv
hw/id_branch_unit.sv
hw/id_stage.sv
sim/id_stage_assertions.sv
sim/id_stage_tb.sv

//--- Makefile
# Verilator flow for the decode stage testbench

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f id_stage.f --top-module id_stage_tb -Mdir obj_dir

run: compile
	-./obj_dir/Vid_stage_tb > sim.log 2>&1
	cat sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
